// File: run_sim.sh
#!/bin/sh
# build the CORDIC testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module cordic_tb -f sim.f

./obj_dir/Vcordic_tb

// File: sim.f
+incdir+verification
src/cordic_pkg.sv
src/cordic_angle_rom.sv
src/cordic_ctrl.sv
src/cordic_datapath.sv
src/cordic_output.sv
src/cordic_top.sv
verification/cordic_tb.sv

// File: src/cordic_angle_rom.sv
`timescale 1ns/100ps

module cordic_angle_rom (
    input  cordic_pkg::coord_t coord,  // selects atan or power-of-two table
    input  cordic_pkg::iter_t  iter,   // micro-rotation index
    output cordic_pkg::acc_t   alpha   // elementary angle in q16.32
);
    import cordic_pkg::*;

    acc_t atan_val;  // atan(2^-i)
    acc_t lin_val;   // 2^-i

    always_comb begin
        case (iter)
            4'd0:  atan_val = 48'sd3373259426;  // 0.785398
            4'd1:  atan_val = 48'sd1991351318;  // 0.463648
            4'd2:  atan_val = 48'sd1052175346;  // 0.244979
            4'd3:  atan_val = 48'sd534100635;
            4'd4:  atan_val = 48'sd268086748;
            4'd5:  atan_val = 48'sd134174063;
            4'd6:  atan_val = 48'sd67103403;
            4'd7:  atan_val = 48'sd33553749;
            4'd8:  atan_val = 48'sd16777131;
            4'd9:  atan_val = 48'sd8388597;
            4'd10: atan_val = 48'sd4194303;
            4'd11: atan_val = 48'sd2097152;   // from here atan(2^-i) rounds to 2^-i
            4'd12: atan_val = 48'sd1048576;
            4'd13: atan_val = 48'sd524288;
            4'd14: atan_val = 48'sd262144;
            4'd15: atan_val = 48'sd131072;
            default: atan_val = '0;
        endcase
    end

    // 1.0 in q16.32 shifted down by the index
    assign lin_val = (acc_t'(1) << FRAC_BITS) >> iter;

    assign alpha = (coord == COORD_CIRCULAR) ? atan_val : lin_val;

endmodule

// File: src/cordic_ctrl.sv
`timescale 1ns/100ps

module cordic_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,  // start strobe, seen only in idle
    output logic              load,    // datapath takes operands
    output logic              step,    // datapath does one micro-rotation
    output logic              finish,  // output stage captures results
    output cordic_pkg::iter_t iter,    // current micro-rotation index
    output logic              valid    // one cycle completion pulse
);
    import cordic_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_comb begin
        state_nxt = state;  // hold by default
        case (state)
            S_IDLE: begin
                if (enable) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD:   state_nxt = S_ITER;
            S_ITER: begin
                if (iter == iter_t'(N_ITER - 1)) begin  // last rotation this cycle
                    state_nxt = S_FINISH;
                end
            end
            S_FINISH: state_nxt = S_IDLE;  // next enable seen one cycle later
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            iter  <= '0;
            valid <= 1'b0;
        end else begin
            state <= state_nxt;
            valid <= finish;  // results are registered on the same edge
            if (state == S_LOAD) begin
                iter <= '0;  // restart index for the new operation
            end else if (state == S_ITER) begin
                iter <= iter + 1'b1;  // wraps to zero after the last rotation
            end
        end
    end

    // strobes decoded from state
    assign load   = (state == S_LOAD);
    assign step   = (state == S_ITER);
    assign finish = (state == S_FINISH);

endmodule

// File: src/cordic_datapath.sv
`timescale 1ns/100ps

module cordic_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,    // take operands and mode
    input  logic                     step,    // one micro-rotation
    input  cordic_pkg::iter_t        iter,    // shift amount for this step
    input  cordic_pkg::word_t        x_in,
    input  cordic_pkg::word_t        y_in,
    input  cordic_pkg::word_t        z_in,
    input  cordic_pkg::cordic_mode_t mode,    // sampled on load only
    input  cordic_pkg::acc_t         alpha,   // elementary angle for iter
    output cordic_pkg::cordic_mode_t mode_q,  // mode held for the whole operation
    output cordic_pkg::cordic_vec_t  vec      // x/y/z working registers
);
    import cordic_pkg::*;

    cordic_vec_t vec_load;  // operands widened to q16.32
    cordic_vec_t vec_step;  // result of one micro-rotation
    acc_t        x_sh;      // x * 2^-i
    acc_t        y_sh;      // y * 2^-i
    logic        sigma;     // 1 rotates positive, 0 negative

    always_comb begin
        vec_load.x = {x_in, {PAD_BITS{1'b0}}};
        vec_load.y = {y_in, {PAD_BITS{1'b0}}};
        vec_load.z = {z_in, {PAD_BITS{1'b0}}};
        if (mode.op == OP_ROTATE && mode.coord == COORD_CIRCULAR) begin
            vec_load.x = K_INV_CIRC;  // pre-scaled unit vector gives cos/sin directly
            vec_load.y = '0;
        end
    end

    // direction of the next rotation
    always_comb begin
        if (mode_q.op == OP_ROTATE) begin
            sigma = ~vec.z[ACC_W-1];  // push z toward zero
        end else begin
            sigma = (vec.x[ACC_W-1] != vec.y[ACC_W-1]);  // push y toward zero
        end
    end

    assign x_sh = vec.x >>> iter;  // arithmetic shift keeps the sign
    assign y_sh = vec.y >>> iter;

    always_comb begin
        vec_step.y = sigma ? (vec.y + x_sh) : (vec.y - x_sh);
        vec_step.z = sigma ? (vec.z - alpha) : (vec.z + alpha);
        if (mode_q.coord == COORD_CIRCULAR) begin
            vec_step.x = sigma ? (vec.x - y_sh) : (vec.x + y_sh);
        end else begin
            vec_step.x = vec.x;  // linear system never moves x
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q <= '0;
        end else if (load) begin
            mode_q <= mode;
        end
    end

    // working registers, no reset
    always_ff @(posedge clk) begin
        if (load) begin
            vec <= vec_load;
        end else if (step) begin
            vec <= vec_step;
        end
    end

endmodule

// File: src/cordic_output.sv
`timescale 1ns/100ps

module cordic_output (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     finish,  // capture strobe
    input  cordic_pkg::cordic_mode_t mode_q,  // mode of the finished operation
    input  cordic_pkg::cordic_vec_t  vec,     // final x/y/z in q16.32
    output cordic_pkg::word_t        x_out,
    output cordic_pkg::word_t        y_out,
    output cordic_pkg::word_t        z_out
);
    import cordic_pkg::*;

    acc_t                     x_abs;   // |x| before gain removal
    logic signed [2*ACC_W-1:0] prod;   // |x| * 1/K, q32.64
    acc_t                     x_gain;  // magnitude back in q16.32
    acc_t                     x_res;   // x chosen for capture

    // keep the upper 32 bits, q16.32 to q16.16
    function automatic word_t to_word(input acc_t v);
        to_word = v[FRAC_BITS-IO_FRAC_BITS +: WORD_W];
    endfunction

    always_comb begin
        x_abs  = vec.x[ACC_W-1] ? -vec.x : vec.x;
        prod   = (2*ACC_W)'(x_abs) * (2*ACC_W)'(K_INV_CIRC);
        x_gain = acc_t'(prod >>> FRAC_BITS);
        if (mode_q.op == OP_VECTOR && mode_q.coord == COORD_CIRCULAR) begin
            x_res = x_gain;  // vectoring grew x by K
        end else begin
            x_res = vec.x;
        end
    end

    // results hold until the next finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_out <= '0;
            y_out <= '0;
            z_out <= '0;
        end else if (finish) begin
            x_out <= to_word(x_res);
            y_out <= to_word(vec.y);
            z_out <= to_word(vec.z);
        end
    end

endmodule

// File: src/cordic_pkg.sv
package cordic_pkg;

    localparam int WORD_W = 32;   // external operand width, q16.16
    localparam int ACC_W  = 48;   // internal working width, q16.32
    localparam int ITER_W = 4;    // wide enough for 16 micro-rotations

    localparam int N_ITER       = 16;  // fixed number of micro-rotations
    localparam int FRAC_BITS    = 32;  // fraction bits inside the engine
    localparam int IO_FRAC_BITS = 16;  // fraction bits at the ports
    localparam int PAD_BITS     = 16;  // zeros appended to widen an operand

    typedef logic signed [WORD_W-1:0] word_t;  // q16.16 operand or result
    typedef logic signed [ACC_W-1:0]  acc_t;   // q16.32 working value
    typedef logic        [ITER_W-1:0] iter_t;  // micro-rotation index

    // 1/K for the circular system, 0.6072529350088813 * 2^32
    localparam acc_t K_INV_CIRC = 48'sd2608131496;

    // coordinate system
    typedef enum logic {
        COORD_LINEAR   = 1'b0,
        COORD_CIRCULAR = 1'b1
    } coord_t;

    // rotation drives z to zero, vectoring drives y to zero
    typedef enum logic {
        OP_ROTATE = 1'b0,
        OP_VECTOR = 1'b1
    } op_t;

    typedef struct packed {
        op_t    op;     // rotate or vector
        coord_t coord;  // linear or circular
    } cordic_mode_t;

    typedef struct packed {
        acc_t x;  // x coordinate
        acc_t y;  // y coordinate
        acc_t z;  // angle or quotient accumulator
    } cordic_vec_t;

    // controller sequence
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,  // waiting for enable
        S_LOAD   = 2'd1,  // operands go into the datapath
        S_ITER   = 2'd2,  // micro-rotations 0 to N_ITER-1
        S_FINISH = 2'd3   // result capture
    } ctrl_state_t;

endpackage

// File: src/cordic_top.sv
`timescale 1ns/100ps

module cordic_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,  // start strobe
    input  cordic_pkg::word_t        x_in,
    input  cordic_pkg::word_t        y_in,
    input  cordic_pkg::word_t        z_in,
    input  cordic_pkg::cordic_mode_t mode,    // operation and coordinate system
    output cordic_pkg::word_t        x_out,
    output cordic_pkg::word_t        y_out,
    output cordic_pkg::word_t        z_out,
    output logic                     valid    // completion pulse
);
    import cordic_pkg::*;

    logic         load;
    logic         step;
    logic         finish;
    iter_t        iter;
    cordic_mode_t mode_q;  // latched at load
    cordic_vec_t  vec;
    acc_t         alpha;

    cordic_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .load   (load),
        .step   (step),
        .finish (finish),
        .iter   (iter),
        .valid  (valid)
    );

    cordic_datapath u_datapath (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .step   (step),
        .iter   (iter),
        .x_in   (x_in),
        .y_in   (y_in),
        .z_in   (z_in),
        .mode   (mode),
        .alpha  (alpha),
        .mode_q (mode_q),
        .vec    (vec)
    );

    // table follows the latched coordinate system
    cordic_angle_rom u_angle_rom (
        .coord (mode_q.coord),
        .iter  (iter),
        .alpha (alpha)
    );

    cordic_output u_output (
        .clk    (clk),
        .rst    (rst),
        .finish (finish),
        .mode_q (mode_q),
        .vec    (vec),
        .x_out  (x_out),
        .y_out  (y_out),
        .z_out  (z_out)
    );

endmodule

// File: verification/cordic_checks.svh
`ifndef CORDIC_CHECKS_SVH
`define CORDIC_CHECKS_SVH

localparam int VALID_TIMEOUT = 40;  // cycles allowed before valid must show up

// prints the reason and ends the run
task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
endtask

// tolerance is in q16.16 lsb
task automatic check_word(input string name, input word_t got, input word_t exp, input int tol);
    longint diff;
    diff = longint'(got) - longint'(exp);
    if (diff < 0) begin
        diff = -diff;
    end
    if ($isunknown(got) || diff > longint'(tol)) begin
        $display("CHECK FAILED at %0t: %s is %0d (%f), expected %0d (%f) within %0d lsb",
                 $time, name, got, to_real(got), exp, to_real(exp), tol);
        stop_with_failure("result outside tolerance");
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        stop_with_failure("control output has the wrong level");
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        stop_with_failure("cycle count is wrong");
    end
endtask

// counts cycles from just after a rising edge until valid
task automatic wait_valid(output int cycles);
    cycles = 0;
    while (valid !== 1'b1) begin
        if (cycles >= VALID_TIMEOUT) begin
            stop_with_failure($sformatf("valid never rose within %0d cycles", VALID_TIMEOUT));
        end else begin
            next_cycle();
            cycles++;
        end
    end
endtask

`endif

// File: verification/cordic_tb.sv
`timescale 1ns/100ps

module cordic_tb;
    import cordic_pkg::*;

    localparam int LATENCY = 18;  // enable edge to valid

    logic         clk;
    logic         rst;
    logic         enable;
    word_t        x_in;
    word_t        y_in;
    word_t        z_in;
    cordic_mode_t mode;
    word_t        x_out;
    word_t        y_out;
    word_t        z_out;
    logic         valid;
    integer       seed;  // $random state

    cordic_top DUT (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .x_in   (x_in),
        .y_in   (y_in),
        .z_in   (z_in),
        .mode   (mode),
        .x_out  (x_out),
        .y_out  (y_out),
        .z_out  (z_out),
        .valid  (valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // 8 ns period
        end
    end

    function automatic real to_real(input word_t w);
        return $itor(w) / 65536.0;
    endfunction

    // nearest q16.16 value
    function automatic word_t to_fix(input real r);
        if (r < 0.0) begin
            return -word_t'($rtoi(0.5 - r * 65536.0));
        end else begin
            return word_t'($rtoi(r * 65536.0 + 0.5));
        end
    endfunction

    function automatic cordic_mode_t make_mode(input op_t op, input coord_t coord);
        cordic_mode_t m;
        m.op    = op;
        m.coord = coord;
        return m;
    endfunction

    `include "cordic_checks.svh"

    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive and sample away from the edge
    endtask

    // enable is sampled on the next rising edge
    task automatic start_op(input cordic_mode_t m, input word_t x, input word_t y, input word_t z);
        mode   = m;
        x_in   = x;
        y_in   = y;
        z_in   = z;
        enable = 1'b1;
        next_cycle();
        enable = 1'b0;
    endtask

    // runs one operation and checks its timing
    task automatic run_op(input cordic_mode_t m, input word_t x, input word_t y, input word_t z);
        int cycles;
        start_op(m, x, y, z);
        wait_valid(cycles);
        check_count("valid latency", cycles, LATENCY);
        next_cycle();
        check_bit("valid", valid, 1'b0);  // single cycle pulse
    endtask

    task automatic check_idle();
        check_bit("valid", valid, 1'b0);
        check_word("x_out", x_out, '0, 0);
        check_word("y_out", y_out, '0, 0);
        check_word("z_out", z_out, '0, 0);
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (16) begin
            next_cycle();
            check_idle();
        end
        rst = 1'b0;
        repeat (3) begin
            next_cycle();
            check_idle();
        end
    endtask

    task automatic test_circ_rot(input real z);
        word_t zf;
        zf = to_fix(z);
        run_op(make_mode(OP_ROTATE, COORD_CIRCULAR), '0, '0, zf);
        check_word("x_out", x_out, to_fix($cos(to_real(zf))), 16);
        check_word("y_out", y_out, to_fix($sin(to_real(zf))), 16);
        check_word("z_out", z_out, '0, 16);  // residual angle
    endtask

    task automatic test_circ_vec(input word_t x, input word_t y, input word_t z);
        real xr;
        real yr;
        xr = to_real(x);
        yr = to_real(y);
        run_op(make_mode(OP_VECTOR, COORD_CIRCULAR), x, y, z);
        check_word("x_out", x_out, to_fix($sqrt(xr * xr + yr * yr)), 32);
        check_word("z_out", z_out, to_fix(to_real(z) + $atan(yr / xr)), 32);
        check_word("y_out", y_out, '0, 64);
    endtask

    task automatic test_lin_rot(input word_t x, input word_t y, input word_t z);
        run_op(make_mode(OP_ROTATE, COORD_LINEAR), x, y, z);
        check_word("y_out", y_out, to_fix(to_real(y) + to_real(x) * to_real(z)), 64);
        check_word("x_out", x_out, x, 0);
    endtask

    task automatic test_lin_vec(input word_t x, input word_t y, input word_t z);
        run_op(make_mode(OP_VECTOR, COORD_LINEAR), x, y, z);
        check_word("z_out", z_out, to_fix(to_real(z) + to_real(y) / to_real(x)), 64);
        check_word("x_out", x_out, x, 0);
    endtask

    // x in [1, 4) and quotient within 1.9
    task automatic random_lin_vec();
        word_t x;
        real   q;
        x = 32'sd65536 + word_t'(($random(seed) & 32'h7fff_ffff) % 196608);
        q = $itor($random(seed) % 124519) / 65536.0;
        test_lin_vec(x, to_fix(q * to_real(x)), word_t'($random(seed) % 32768));
    endtask

    task automatic test_timing();
        int cycles;
        // known results to watch while the next operation runs
        run_op(make_mode(OP_VECTOR, COORD_LINEAR), to_fix(2.0), to_fix(1.0), to_fix(0.25));
        start_op(make_mode(OP_ROTATE, COORD_LINEAR), to_fix(1.5), to_fix(0.25), to_fix(-0.75));
        next_cycle();
        next_cycle();
        // this start comes while busy and must be ignored
        start_op(make_mode(OP_ROTATE, COORD_CIRCULAR), to_fix(0.3), to_fix(0.6), to_fix(1.0));
        check_word("x_out", x_out, to_fix(2.0), 0);  // old results still held
        check_word("y_out", y_out, '0, 64);
        check_word("z_out", z_out, to_fix(0.25 + 1.0 / 2.0), 64);
        wait_valid(cycles);
        check_count("valid latency", cycles + 3, LATENCY);
        check_word("y_out", y_out, to_fix(0.25 - 1.5 * 0.75), 64);
        check_word("x_out", x_out, to_fix(1.5), 0);
        // enable is sampled on the edge that ends valid
        start_op(make_mode(OP_VECTOR, COORD_CIRCULAR), to_fix(3.0), to_fix(4.0), '0);
        check_bit("valid", valid, 1'b0);
        check_word("y_out", y_out, to_fix(0.25 - 1.5 * 0.75), 64);
        wait_valid(cycles);
        check_count("valid latency", cycles, LATENCY);
        check_word("x_out", x_out, to_fix(5.0), 32);
        check_word("z_out", z_out, to_fix($atan(4.0 / 3.0)), 32);
        next_cycle();
        check_bit("valid", valid, 1'b0);
    endtask

    initial begin
        seed   = 32'hcdda_9887;
        rst    = 1'b1;
        enable = 1'b0;
        x_in   = '0;
        y_in   = '0;
        z_in   = '0;
        mode   = '0;
        test_reset();
        test_circ_rot(0.0);
        test_circ_rot(0.5);
        test_circ_rot(-0.5);
        test_circ_rot(1.0);
        test_circ_rot(-1.0);
        test_circ_rot(1.5);
        test_circ_rot(3.14159265358979 / 4.0);
        test_circ_vec(to_fix(1.0), to_fix(0.0), to_fix(0.0));
        test_circ_vec(to_fix(3.0), to_fix(4.0), to_fix(0.0));
        test_circ_vec(to_fix(3.0), to_fix(-4.0), to_fix(0.25));
        test_circ_vec(to_fix(0.5), to_fix(2.0), to_fix(0.0));
        test_circ_vec(to_fix(10.0), to_fix(-7.5), to_fix(-0.5));
        repeat (8) begin  // x in [1, 9) and |y| below 8
            test_circ_vec(32'sd65536 + word_t'($random(seed) & 32'h7_ffff),
                          word_t'($random(seed) % 524288), word_t'($random(seed) % 16384));
        end
        repeat (8) begin  // x and y within 4 and z within 1.9
            test_lin_rot(word_t'($random(seed) % 262145), word_t'($random(seed) % 262145),
                         word_t'($random(seed) % 124519));
        end
        repeat (8) begin
            random_lin_vec();
        end
        test_timing();
        $display("** PASS **");
        $finish;
    end

endmodule
